// ==== Bender.yml ====
package:
  name: fu_ctrl

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - common/fu_ctrl_pkg.sv
      - verilog/inst_decode.sv
      - scoreboard/hazard_check.sv
      - scoreboard/wb_scoreboard.sv
      - verilog/fu_ctrl.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/fu_ctrl_tb.sv

// ==== common/fu_ctrl_pkg.sv ====
package fu_ctrl_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  lat_t;  // Latency or reservation slot index

    // Unit class, doubles as writeback source select
    typedef enum logic [2:0] {
        FU_NONE = 3'd0,
        FU_ALU  = 3'd1,
        FU_MEM  = 3'd2,
        FU_MUL  = 3'd3,
        FU_DIV  = 3'd4,
        FU_JUMP = 3'd5
    } fu_e;

    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_AND  = 4'd3,
        ALU_OR   = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_AP4  = 4'd11,
        ALU_BOUT = 4'd12  // Pass operand B
    } alu_op_e;

    typedef enum logic [3:0] {
        JUMP_JAL  = 4'd0,
        JUMP_BEQ  = 4'd1,
        JUMP_BNE  = 4'd2,
        JUMP_BLT  = 4'd3,
        JUMP_BGE  = 4'd4,
        JUMP_BLTU = 4'd5,
        JUMP_BGEU = 4'd6,
        JUMP_JALR = 4'd8
    } jump_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_B    = 3'd2,
        IMM_J    = 3'd3,
        IMM_S    = 3'd4,
        IMM_U    = 3'd5
    } imm_sel_e;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_B     = 7'b1100011;
    localparam logic [6:0] OPC_L     = 7'b0000011;
    localparam logic [6:0] OPC_S     = 7'b0100011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;

    localparam int FU_COUNT  = 6;   // Includes the none entry
    localparam int RES_DEPTH = 32;

    localparam int unsigned ALU_LAT     = 1;
    localparam int unsigned MEM_LAT     = 2;
    localparam int unsigned JUMP_LAT    = 2;
    localparam int unsigned DEF_MUL_LAT = 7;
    localparam int unsigned DEF_DIV_LAT = 24;

    function automatic lat_t fu_latency(fu_e fu, int unsigned mul_lat, int unsigned div_lat);
        case (fu)
            FU_ALU:  return lat_t'(ALU_LAT);
            FU_MEM:  return lat_t'(MEM_LAT);
            FU_MUL:  return lat_t'(mul_lat);
            FU_DIV:  return lat_t'(div_lat);
            FU_JUMP: return lat_t'(JUMP_LAT);
            default: return '0;
        endcase
    endfunction

endpackage

// ==== fu_ctrl.f ====
common/fu_ctrl_pkg.sv
verilog/inst_decode.sv
scoreboard/hazard_check.sv
scoreboard/wb_scoreboard.sv
verilog/fu_ctrl.sv
sim/tb_clk_gen.sv
sim/fu_ctrl_tb.sv

// ==== scoreboard/hazard_check.sv ====
`timescale 1ns/1ps

module hazard_check import fu_ctrl_pkg::*; #(
    parameter int unsigned MUL_LAT = DEF_MUL_LAT,
    parameter int unsigned DIV_LAT = DEF_DIV_LAT
) (
    input  fu_e                            fu_class,
    input  reg_addr_t                      rd,
    input  reg_addr_t                      rs1,
    input  reg_addr_t                      rs2,
    input  fu_e       [RES_DEPTH-1:0]      res_slots,
    input  logic      [FU_COUNT-1:0]       fu_busy,
    input  reg_addr_t [FU_COUNT-1:0]       fu_dest,
    output logic                           hazard
);

    lat_t lat;
    logic raw_rs1;
    logic raw_rs2;
    logic waw;
    logic wb_conflict;
    logic unit_busy;

    assign lat = fu_latency(fu_class, MUL_LAT, DIV_LAT);

    // Any busy unit still owes a write to the source
    always_comb begin
        raw_rs1 = 1'b0;
        raw_rs2 = 1'b0;
        for (int u = 1; u < FU_COUNT; u++) begin
            if (fu_busy[u] && rs1 != '0 && fu_dest[u] == rs1) begin
                raw_rs1 = 1'b1;
            end
            if (fu_busy[u] && rs2 != '0 && fu_dest[u] == rs2) begin
                raw_rs2 = 1'b1;
            end
        end
    end

    // Older write lands no earlier than the new one
    always_comb begin
        waw = 1'b0;
        for (int i = 0; i < RES_DEPTH; i++) begin
            if (res_slots[i] != FU_NONE && i >= int'(lat) && fu_busy[res_slots[i]] &&
                fu_dest[res_slots[i]] == rd) begin
                waw = 1'b1;
            end
        end
        if (rd == '0) begin
            waw = 1'b0;
        end
    end

    // Slot L shifts into L-1 at the issue edge
    assign wb_conflict = res_slots[lat] != FU_NONE;

    assign unit_busy = fu_busy[fu_class] && res_slots[0] != fu_class;

    assign hazard = fu_class != FU_NONE &&
                    (raw_rs1 || raw_rs2 || waw || wb_conflict || unit_busy);

endmodule

// ==== scoreboard/wb_scoreboard.sv ====
`timescale 1ns/1ps

module wb_scoreboard import fu_ctrl_pkg::*; #(
    parameter int unsigned MUL_LAT = DEF_MUL_LAT,
    parameter int unsigned DIV_LAT = DEF_DIV_LAT
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid_id,
    input  fu_e                       fu_class,
    input  reg_addr_t                 rd,
    input  logic                      rd_used,
    input  logic                      is_branch,
    input  logic                      is_jump,
    input  logic                      hazard,
    input  logic                      cmp_res_fu,
    output fu_e       [RES_DEPTH-1:0] res_slots,
    output logic      [FU_COUNT-1:0]  fu_busy,
    output reg_addr_t [FU_COUNT-1:0]  fu_dest,
    output logic                      issue_ready,
    output logic                      branch_ctrl,
    output logic                      reg_id_flush,
    output logic                      issue_fire,
    output fu_e                       write_sel,
    output reg_addr_t                 rd_ctrl,
    output logic                      reg_write
);

    logic [FU_COUNT-1:0] fu_wen;
    logic                b_in_fu;
    logic                j_in_fu;
    logic                flush_pending;
    logic                issue;
    lat_t                lat;

    assign lat = fu_latency(fu_class, MUL_LAT, DIV_LAT);

    assign branch_ctrl  = (b_in_fu && cmp_res_fu) || j_in_fu;
    assign reg_id_flush = branch_ctrl;
    assign issue_ready  = !hazard || branch_ctrl;

    assign issue_fire = valid_id && issue_ready && !hazard && !reg_id_flush && !flush_pending;
    assign issue      = issue_fire && fu_class != FU_NONE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < RES_DEPTH; i++) begin
                res_slots[i] <= FU_NONE;
            end
        end else begin
            for (int i = 0; i < RES_DEPTH - 1; i++) begin
                res_slots[i] <= res_slots[i+1];
            end
            res_slots[RES_DEPTH-1] <= FU_NONE;
            if (issue) begin
                res_slots[lat - 5'd1] <= fu_class;  // Reaches slot 0 after L-1 more edges
            end
        end
    end

    // Unit tables, issue wins over a same-unit writeback
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fu_busy <= '0;
            fu_wen  <= '0;
            fu_dest <= '0;
        end else begin
            if (res_slots[0] != FU_NONE) begin
                fu_busy[res_slots[0]] <= 1'b0;
                fu_wen[res_slots[0]]  <= 1'b0;
                fu_dest[res_slots[0]] <= '0;
            end
            if (issue) begin
                fu_busy[fu_class] <= 1'b1;
                fu_wen[fu_class]  <= rd_used;
                fu_dest[fu_class] <= rd_used ? rd : '0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            b_in_fu       <= 1'b0;
            j_in_fu       <= 1'b0;
            flush_pending <= 1'b0;
        end else begin
            b_in_fu       <= issue && is_branch;
            j_in_fu       <= issue && is_jump;
            flush_pending <= branch_ctrl;  // Second squash cycle
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_sel <= FU_NONE;
            rd_ctrl   <= '0;
            reg_write <= 1'b0;
        end else begin
            write_sel <= res_slots[0];
            rd_ctrl   <= fu_dest[res_slots[0]];
            reg_write <= fu_wen[res_slots[0]];
        end
    end

endmodule

// ==== sim/fu_ctrl_tb.sv ====
`timescale 1ns/1ps

module fu_ctrl_tb import fu_ctrl_pkg::*; ();

    localparam int MAX_CYC         = 2100;
    localparam int WATCHDOG_CYCLES = 2000;

    logic      clk;
    logic      rst;
    inst_t     inst;
    logic      valid_id;
    logic      cmp_res_fu;
    logic      issue_ready, branch_ctrl, reg_id_flush;
    imm_sel_e  imm_sel;
    alu_op_e   alu_op;
    jump_op_e  jump_op;
    logic      alu_src_a, alu_src_b, mem_we;
    logic      alu_en, mem_en, mul_en, div_en, jump_en;
    fu_e       write_sel;
    reg_addr_t rd_ctrl;
    logic      reg_write;

    int        errors = 0;
    int        cyc = 0;
    logic      wb_pending [MAX_CYC];  // Expected writeback per cycle
    fu_e       wb_sel     [MAX_CYC];
    reg_addr_t wb_rd      [MAX_CYC];
    logic      wb_we      [MAX_CYC];

    tb_clk_gen u_clk (.clk);

    fu_ctrl dut (.*);

    always @(posedge clk) cyc <= cyc + 1;

    function automatic int unit_latency(fu_e cls);
        case (cls)
            FU_ALU:  return 1;
            FU_MEM:  return 2;
            FU_MUL:  return 7;
            FU_DIV:  return 24;
            FU_JUMP: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic logic [4:0] enables_for(fu_e cls);
        return {cls == FU_ALU, cls == FU_MEM, cls == FU_MUL, cls == FU_DIV, cls == FU_JUMP};
    endfunction

    // R layout, also used for I, S and B words with zero immediate bits
    function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, reg_addr_t rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(31, 1));
    endfunction

    function automatic reg_addr_t other_reg(reg_addr_t r);
        return (r == 5'd31) ? 5'd1 : r + 5'd1;
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle(int n);
        repeat (n) tick();
    endtask

    task automatic expect_wb(fu_e cls, reg_addr_t rd, logic we, int e);
        int idx;
        idx = e + unit_latency(cls);
        assert (!wb_pending[idx]) else begin
            errors++;
            $display("Two writebacks fall into cycle %0d", idx);
        end
        wb_pending[idx] = 1'b1;
        wb_sel[idx]     = cls;
        wb_rd[idx]      = rd;
        wb_we[idx]      = we;
    endtask

    // Holds the word until its unit enable fires, returns the issue edge
    task automatic issue(input inst_t word, input fu_e cls, input logic used,
                         output int e, output int stalls, output int ready_hi);
        logic hit;
        e = -1;
        stalls = 0;
        ready_hi = 0;
        inst = word;
        valid_id = 1'b1;
        #1;
        while ((enables_for(cls) & {alu_en, mem_en, mul_en, div_en, jump_en}) == '0 &&
               stalls < 64) begin
            ready_hi += int'(issue_ready);
            tick();
            stalls++;
            #1;
        end
        hit = (enables_for(cls) & {alu_en, mem_en, mul_en, div_en, jump_en}) != '0;
        assert (hit) else begin
            errors++;
            $display("Instruction %h was not issued within 64 cycles", word);
        end
        if (hit) begin
            check_val("unit enables", enables_for(cls),
                      {alu_en, mem_en, mul_en, div_en, jump_en});
        end
        tick();
        if (hit) begin
            e = cyc;
            expect_wb(cls, used ? word[11:7] : 5'd0, used, e);
        end
        valid_id = 1'b0;
        inst = '0;
    endtask

    task automatic single_writeback(inst_t word, fu_e cls, logic used);
        int e, stalls, ready_hi;
        issue(word, cls, used, e, stalls, ready_hi);
        check_val("stall cycles", 0, stalls);
        idle(unit_latency(cls) + 3);  // Drain before the next one
    endtask

    task automatic decode_case(string tag, inst_t word, fu_e cls, logic used, alu_op_e aop,
                               jump_op_e jop, imm_sel_e imm, logic sa, logic sb, logic we);
        inst = word;
        #1;
        check_val({tag, " alu_op"}, aop, alu_op);
        if (cls == FU_JUMP) check_val({tag, " jump_op"}, jop, jump_op);
        check_val({tag, " imm_sel"}, imm, imm_sel);
        check_val({tag, " alu_src_a"}, sa, alu_src_a);
        check_val({tag, " alu_src_b"}, sb, alu_src_b);
        check_val({tag, " mem_we"}, we, mem_we);
        tick();
        single_writeback(word, cls, used);
    endtask

    task automatic reset_state();
        #1;
        check_val("reg_write", 0, reg_write);
        check_val("write_sel", FU_NONE, write_sel);
        check_val("branch_ctrl", 0, branch_ctrl);
        check_val("reg_id_flush", 0, reg_id_flush);
        check_val("unit enables", 0, {alu_en, mem_en, mul_en, div_en, jump_en});
        check_val("issue_ready", 1, issue_ready);
    endtask

    task automatic decode_tests();
        decode_case("ADD", enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R),
                    FU_ALU, 1'b1, ALU_ADD, JUMP_JAL, IMM_NONE, 1'b0, 1'b0, 1'b0);
        decode_case("SUB", enc_r(7'h20, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R),
                    FU_ALU, 1'b1, ALU_SUB, JUMP_JAL, IMM_NONE, 1'b0, 1'b0, 1'b0);
        decode_case("ADDI", enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_I),
                    FU_ALU, 1'b1, ALU_ADD, JUMP_JAL, IMM_I, 1'b0, 1'b1, 1'b0);
        decode_case("SRAI", enc_r(7'h20, rand_reg(), rand_reg(), 3'h5, rand_reg(), OPC_I),
                    FU_ALU, 1'b1, ALU_SRA, JUMP_JAL, IMM_I, 1'b0, 1'b1, 1'b0);
        decode_case("LUI", enc_u(20'h12345, rand_reg(), OPC_LUI),
                    FU_ALU, 1'b1, ALU_BOUT, JUMP_JAL, IMM_U, 1'b0, 1'b1, 1'b0);
        decode_case("AUIPC", enc_u(20'h00abc, rand_reg(), OPC_AUIPC),
                    FU_ALU, 1'b1, ALU_ADD, JUMP_JAL, IMM_U, 1'b1, 1'b1, 1'b0);
        decode_case("LW", enc_r(7'h00, rand_reg(), rand_reg(), 3'h2, rand_reg(), OPC_L),
                    FU_MEM, 1'b1, ALU_NONE, JUMP_JAL, IMM_I, 1'b0, 1'b0, 1'b0);
        decode_case("SW", enc_r(7'h00, rand_reg(), rand_reg(), 3'h2, 5'd0, OPC_S),
                    FU_MEM, 1'b0, ALU_NONE, JUMP_JAL, IMM_S, 1'b0, 1'b0, 1'b1);
        decode_case("BNE", enc_r(7'h00, rand_reg(), rand_reg(), 3'h1, 5'd0, OPC_B),
                    FU_JUMP, 1'b0, ALU_NONE, JUMP_BNE, IMM_B, 1'b0, 1'b0, 1'b0);
        decode_case("JAL", enc_u(20'h00000, rand_reg(), OPC_JAL),
                    FU_JUMP, 1'b1, ALU_NONE, JUMP_JAL, IMM_J, 1'b0, 1'b0, 1'b0);
        decode_case("JALR", enc_r(7'h00, 5'd0, rand_reg(), 3'h0, rand_reg(), OPC_JALR),
                    FU_JUMP, 1'b1, ALU_NONE, JUMP_JALR, IMM_I, 1'b0, 1'b0, 1'b0);
        decode_case("MUL", enc_r(7'h01, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R),
                    FU_MUL, 1'b1, ALU_NONE, JUMP_JAL, IMM_NONE, 1'b0, 1'b0, 1'b0);
        decode_case("DIVU", enc_r(7'h01, rand_reg(), rand_reg(), 3'h5, rand_reg(), OPC_R),
                    FU_DIV, 1'b1, ALU_NONE, JUMP_JAL, IMM_NONE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic writeback_tests();
        single_writeback(enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R), FU_ALU, 1);
        single_writeback(enc_r(7'h00, rand_reg(), rand_reg(), 3'h2, rand_reg(), OPC_L), FU_MEM, 1);
        single_writeback(enc_r(7'h00, rand_reg(), rand_reg(), 3'h2, 5'd0, OPC_S), FU_MEM, 0);
        single_writeback(enc_r(7'h01, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R), FU_MUL, 1);
        single_writeback(enc_r(7'h01, rand_reg(), rand_reg(), 3'h4, rand_reg(), OPC_R), FU_DIV, 1);
        single_writeback(enc_u(20'h00000, rand_reg(), OPC_JAL), FU_JUMP, 1);
    endtask

    task automatic raw_stall();
        int e_mul, e_add, stalls, ready_hi;
        issue(enc_r(7'h01, rand_reg(), rand_reg(), 3'h0, 5'd5, OPC_R), FU_MUL, 1'b1,
              e_mul, stalls, ready_hi);
        issue(enc_r(7'h00, rand_reg(), 5'd5, 3'h0, rand_reg(), OPC_R), FU_ALU, 1'b1,
              e_add, stalls, ready_hi);
        check_val("ADD issue edge", e_mul + 7 + 1, e_add);  // Edge after the MUL writeback
        check_val("issue_ready high cycles in stall", 0, ready_hi);
        idle(5);
    endtask

    task automatic busy_and_conflict();
        int e1, e2, stalls, ready_hi;
        reg_addr_t r;
        r = rand_reg();
        issue(enc_r(7'h01, rand_reg(), rand_reg(), 3'h4, r, OPC_R), FU_DIV, 1'b1,
              e1, stalls, ready_hi);
        issue(enc_r(7'h01, other_reg(r), other_reg(r), 3'h4, rand_reg(), OPC_R), FU_DIV, 1'b1,
              e2, stalls, ready_hi);
        check_val("second DIV issue edge", e1 + 24, e2);
        idle(30);
        r = rand_reg();
        issue(enc_r(7'h01, rand_reg(), rand_reg(), 3'h0, r, OPC_R), FU_MUL, 1'b1,
              e1, stalls, ready_hi);
        idle(5);  // ALU would now land in the MUL writeback cycle
        issue(enc_r(7'h00, other_reg(r), other_reg(r), 3'h0, rand_reg(), OPC_R), FU_ALU, 1'b1,
              e2, stalls, ready_hi);
        check_val("ALU issue edge", e1 + 7, e2);
        idle(5);
    endtask

    task automatic redirect();
        int e, stalls, ready_hi;
        inst_t add_w;
        add_w = enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, rand_reg(), OPC_R);
        issue(enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, 5'd0, OPC_B), FU_JUMP, 1'b0,
              e, stalls, ready_hi);
        cmp_res_fu = 1'b1;
        inst = add_w;
        valid_id = 1'b1;
        #1;
        check_val("branch_ctrl", 1, branch_ctrl);
        check_val("reg_id_flush", 1, reg_id_flush);
        check_val("unit enables", 0, {alu_en, mem_en, mul_en, div_en, jump_en});
        tick();
        cmp_res_fu = 1'b0;
        #1;
        check_val("unit enables", 0, {alu_en, mem_en, mul_en, div_en, jump_en});
        tick();
        issue(add_w, FU_ALU, 1'b1, e, stalls, ready_hi);
        check_val("stall cycles after squash", 0, stalls);
        issue(enc_r(7'h00, rand_reg(), rand_reg(), 3'h0, 5'd0, OPC_B), FU_JUMP, 1'b0,
              e, stalls, ready_hi);
        #1;
        check_val("branch_ctrl", 0, branch_ctrl);  // Not taken
        idle(4);
        issue(enc_u(20'h00000, rand_reg(), OPC_JAL), FU_JUMP, 1'b1, e, stalls, ready_hi);
        #1;
        check_val("branch_ctrl", 1, branch_ctrl);
        check_val("reg_id_flush", 1, reg_id_flush);
        idle(4);
    endtask

    // Writeback outputs compared every cycle, mid-period
    initial begin
        forever begin
            @(posedge clk);
            #2;
            if (wb_pending[cyc]) begin
                check_val("write_sel", wb_sel[cyc], write_sel);
                check_val("rd_ctrl", wb_rd[cyc], rd_ctrl);
                check_val("reg_write", wb_we[cyc], reg_write);
            end else begin
                check_val("write_sel", FU_NONE, write_sel);
                check_val("reg_write", 0, reg_write);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h67c8));
        rst = 1'b1;
        inst = '0;
        valid_id = 1'b0;
        cmp_res_fu = 1'b0;
        foreach (wb_pending[i]) wb_pending[i] = 1'b0;
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;
        reset_state();
        tick();
        decode_tests();
        writeback_tests();
        raw_stall();
        busy_and_conflict();
        redirect();
        idle(30);
        $display("Checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== verilog/fu_ctrl.sv ====
`timescale 1ns/1ps

module fu_ctrl import fu_ctrl_pkg::*; #(
    parameter int unsigned MUL_LAT = DEF_MUL_LAT,
    parameter int unsigned DIV_LAT = DEF_DIV_LAT
) (
    input  logic      clk,
    input  logic      rst,
    input  inst_t     inst,
    input  logic      valid_id,
    input  logic      cmp_res_fu,
    output logic      issue_ready,
    output logic      branch_ctrl,
    output logic      reg_id_flush,
    output imm_sel_e  imm_sel,
    output alu_op_e   alu_op,
    output jump_op_e  jump_op,
    output logic      alu_src_a,
    output logic      alu_src_b,
    output logic      mem_we,
    output logic      alu_en,
    output logic      mem_en,
    output logic      mul_en,
    output logic      div_en,
    output logic      jump_en,
    output fu_e       write_sel,
    output reg_addr_t rd_ctrl,
    output logic      reg_write
);

    fu_e                       fu_class;
    reg_addr_t                 rd;
    reg_addr_t                 rs1;
    reg_addr_t                 rs2;
    logic                      rd_used;
    logic                      is_branch;
    logic                      is_jump;
    logic                      hazard;
    logic                      issue_fire;
    fu_e       [RES_DEPTH-1:0] res_slots;
    logic      [FU_COUNT-1:0]  fu_busy;
    reg_addr_t [FU_COUNT-1:0]  fu_dest;

    inst_decode u_decode (
        .inst, .fu_class, .rd, .rs1, .rs2, .rd_used, .is_branch, .is_jump,
        .imm_sel, .alu_op, .jump_op, .alu_src_a, .alu_src_b, .mem_we
    );

    hazard_check #(.MUL_LAT(MUL_LAT), .DIV_LAT(DIV_LAT)) u_hazard (
        .fu_class, .rd, .rs1, .rs2, .res_slots, .fu_busy, .fu_dest, .hazard
    );

    wb_scoreboard #(.MUL_LAT(MUL_LAT), .DIV_LAT(DIV_LAT)) u_scoreboard (
        .clk, .rst, .valid_id, .fu_class, .rd, .rd_used, .is_branch, .is_jump,
        .hazard, .cmp_res_fu, .res_slots, .fu_busy, .fu_dest, .issue_ready,
        .branch_ctrl, .reg_id_flush, .issue_fire, .write_sel, .rd_ctrl, .reg_write
    );

    assign alu_en  = issue_fire && fu_class == FU_ALU;
    assign mem_en  = issue_fire && fu_class == FU_MEM;
    assign mul_en  = issue_fire && fu_class == FU_MUL;
    assign div_en  = issue_fire && fu_class == FU_DIV;
    assign jump_en = issue_fire && fu_class == FU_JUMP;

endmodule

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode import fu_ctrl_pkg::*; (
    input  inst_t     inst,
    output fu_e       fu_class,
    output reg_addr_t rd,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output logic      rd_used,
    output logic      is_branch,
    output logic      is_jump,
    output imm_sel_e  imm_sel,
    output alu_op_e   alu_op,
    output jump_op_e  jump_op,
    output logic      alu_src_a,
    output logic      alu_src_b,
    output logic      mem_we
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    // Shared by register and immediate ALU forms
    function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt);
        case (f3)
            3'h0:    return alt ? ALU_SUB : ALU_ADD;
            3'h1:    return ALU_SLL;
            3'h2:    return ALU_SLT;
            3'h3:    return ALU_SLTU;
            3'h4:    return ALU_XOR;
            3'h5:    return alt ? ALU_SRA : ALU_SRL;
            3'h6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        fu_class  = FU_NONE;
        rd_used   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        imm_sel   = IMM_NONE;
        alu_op    = ALU_NONE;
        jump_op   = JUMP_JAL;
        alu_src_a = 1'b0;
        alu_src_b = 1'b0;
        mem_we    = 1'b0;
        case (opcode)
            OPC_R: begin
                if (funct7 == 7'h01) begin
                    fu_class = funct3[2] ? FU_DIV : FU_MUL;  // DIV and REM in upper half
                    rd_used  = 1'b1;
                end else if (funct7 == 7'h00 ||
                             (funct7 == 7'h20 && (funct3 == 3'h0 || funct3 == 3'h5))) begin
                    fu_class = FU_ALU;
                    rd_used  = 1'b1;
                    alu_op   = alu_sel(funct3, funct7[5]);
                end
            end
            OPC_I: begin
                if ((funct3 != 3'h1 && funct3 != 3'h5) || funct7 == 7'h00 ||
                    (funct3 == 3'h5 && funct7 == 7'h20)) begin
                    fu_class  = FU_ALU;
                    rd_used   = 1'b1;
                    imm_sel   = IMM_I;
                    alu_src_b = 1'b1;
                    alu_op    = alu_sel(funct3, funct3 == 3'h5 && funct7[5]);  // Only SRAI
                end
            end
            OPC_B: begin
                if (funct3 != 3'h2 && funct3 != 3'h3) begin
                    fu_class  = FU_JUMP;
                    is_branch = 1'b1;
                    imm_sel   = IMM_B;
                    case (funct3)
                        3'h0:    jump_op = JUMP_BEQ;
                        3'h1:    jump_op = JUMP_BNE;
                        3'h4:    jump_op = JUMP_BLT;
                        3'h5:    jump_op = JUMP_BGE;
                        3'h6:    jump_op = JUMP_BLTU;
                        default: jump_op = JUMP_BGEU;
                    endcase
                end
            end
            OPC_L: begin
                if (funct3 != 3'h3 && funct3 < 3'h6) begin  // LB LH LW LBU LHU
                    fu_class = FU_MEM;
                    rd_used  = 1'b1;
                    imm_sel  = IMM_I;
                end
            end
            OPC_S: begin
                if (funct3 <= 3'h2) begin
                    fu_class = FU_MEM;
                    imm_sel  = IMM_S;
                    mem_we   = 1'b1;
                end
            end
            OPC_LUI: begin
                fu_class  = FU_ALU;
                rd_used   = 1'b1;
                imm_sel   = IMM_U;
                alu_src_b = 1'b1;
                alu_op    = ALU_BOUT;
            end
            OPC_AUIPC: begin
                fu_class  = FU_ALU;
                rd_used   = 1'b1;
                imm_sel   = IMM_U;
                alu_src_a = 1'b1;  // PC as operand A
                alu_src_b = 1'b1;
                alu_op    = ALU_ADD;
            end
            OPC_JAL: begin
                fu_class = FU_JUMP;
                rd_used  = 1'b1;
                is_jump  = 1'b1;
                imm_sel  = IMM_J;
                jump_op  = JUMP_JAL;
            end
            OPC_JALR: begin
                if (funct3 == 3'h0) begin
                    fu_class = FU_JUMP;
                    rd_used  = 1'b1;
                    is_jump  = 1'b1;
                    imm_sel  = IMM_I;
                    jump_op  = JUMP_JALR;
                end
            end
            default: ;
        endcase
    end

endmodule
